//--- src/lcd_pkg.sv
// ==============================
// lcd package
// escape-sequence byte codes and bus widths for the serial LCD driver
// ==============================

package lcd_pkg;

	localparam int byte_w = 8;

	typedef logic [byte_w-1:0] char_t;

	// every display command starts with esc followed by a left bracket
	localparam char_t esc_code = 8'h1B;
	localparam char_t csi_code = 8'h5B;

	localparam char_t reset_code = 8'h2A;   // '*' closes the display reset
	localparam char_t clear_code = 8'h6A;   // 'j' closes the clear
	localparam char_t sep_code = 8'h3B;     // ';' between row and column
	localparam char_t cursor_code = 8'h48;  // 'H' closes the cursor move

	// row and column numbers go out as ASCII digits
	localparam char_t digit_zero = 8'h30;

endpackage

//--- src/lcd_sequencer.sv
// ==============================
// lcd sequencer
// walks reset, clear, cursor and message and raises one request at a time
// ==============================
`timescale 1ns/100ps

module lcd_sequencer #(
	parameter int msg_len = 11,
	parameter logic [lcd_pkg::byte_w*msg_len-1:0] message = "hello world"
) (
	input  logic lcdclk,
	input  logic lcdreset,
	input  logic hold,
	input  logic reset_done,
	input  logic clear_done,
	input  logic cursor_done,
	input  logic data_done,
	output logic start,
	output logic reset_req,
	output logic clear_req,
	output logic cursor_req,
	output logic data_req,
	output lcd_pkg::char_t char_out
);

	localparam int idx_w = $clog2(msg_len + 1);
	localparam logic [idx_w-1:0] last_idx = idx_w'(msg_len - 1);

	localparam logic [3:0] st_idle = 4'd0;
	localparam logic [3:0] st_start_reset = 4'd1;
	localparam logic [3:0] st_reset = 4'd2;
	localparam logic [3:0] st_start_clear = 4'd3;
	localparam logic [3:0] st_clear = 4'd4;
	localparam logic [3:0] st_start_cursor = 4'd5;
	localparam logic [3:0] st_cursor = 4'd6;
	localparam logic [3:0] st_start_data = 4'd7;
	localparam logic [3:0] st_data = 4'd8;

	logic [3:0] state;
	logic [idx_w-1:0] chr_idx;

	always_ff @(posedge lcdclk) begin
		if (lcdreset) begin
			state <= st_idle;
			chr_idx <= '0;
		end else if (hold) begin
			state <= st_idle;  // the next pass begins with a display reset
		end else begin
			case (state)
				st_idle: state <= st_start_reset;
				st_start_reset: state <= st_reset;
				st_reset: if (reset_done) state <= st_start_clear;
				st_start_clear: state <= st_clear;
				st_clear: if (clear_done) state <= st_start_cursor;
				st_start_cursor: state <= st_cursor;
				st_cursor: begin
					if (cursor_done) begin
						chr_idx <= '0;
						state <= st_start_data;
					end
				end
				st_start_data: state <= st_data;
				st_data: begin
					if (data_done) begin
						if (chr_idx == last_idx) begin
							state <= st_start_reset;  // whole message written so loop
						end else begin
							chr_idx <= chr_idx + 1'b1;
							state <= st_start_data;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// a start pulse sits between commands to rewind the encoder
	assign start = (state == st_start_reset) | (state == st_start_clear) |
		(state == st_start_cursor) | (state == st_start_data);
	assign reset_req = (state == st_reset);
	assign clear_req = (state == st_clear);
	assign cursor_req = (state == st_cursor);
	assign data_req = (state == st_data);

	assign char_out = message[(msg_len - 1 - int'(chr_idx)) * lcd_pkg::byte_w +: lcd_pkg::byte_w];

endmodule

//--- src/lcd_command_encoder.sv
// ==============================
// lcd command encoder
// expands each request into its escape or character bytes
// ==============================
`timescale 1ns/100ps

module lcd_command_encoder #(
	parameter int start_col = 0
) (
	input  logic lcdclk,
	input  logic lcdreset,
	input  logic start,
	input  logic reset_req,
	input  logic clear_req,
	input  logic cursor_req,
	input  logic data_req,
	input  lcd_pkg::char_t char_in,
	input  logic busy,
	output logic load,
	output lcd_pkg::char_t tx_byte,
	output logic reset_done,
	output logic clear_done,
	output logic cursor_done,
	output logic data_done
);

	logic [2:0] byte_idx;
	logic [2:0] cmd_len;
	logic in_flight;
	logic active;
	logic frame_end;
	logic last_byte;
	lcd_pkg::char_t col_digit;

	assign col_digit = lcd_pkg::char_t'(lcd_pkg::digit_zero + start_col);
	assign active = reset_req | clear_req | cursor_req | data_req;

	always_comb begin
		if (cursor_req)
			cmd_len = 3'd6;
		else if (data_req)
			cmd_len = 3'd1;
		else
			cmd_len = 3'd3;  // reset and clear are both three bytes
	end

	always_comb begin
		case (byte_idx)
			3'd0: tx_byte = data_req ? char_in : lcd_pkg::esc_code;
			3'd1: tx_byte = lcd_pkg::csi_code;
			3'd2: begin
				if (reset_req)
					tx_byte = lcd_pkg::reset_code;
				else if (clear_req)
					tx_byte = lcd_pkg::clear_code;
				else
					tx_byte = lcd_pkg::digit_zero;  // cursor row is always 0
			end
			3'd3: tx_byte = lcd_pkg::sep_code;
			3'd4: tx_byte = col_digit;
			default: tx_byte = lcd_pkg::cursor_code;
		endcase
	end

	// in_flight covers the cycle of the load itself, before busy rises
	assign frame_end = in_flight & ~busy;
	assign last_byte = (byte_idx == cmd_len);
	assign load = active & ~busy & ~in_flight & (byte_idx < cmd_len);

	assign reset_done = frame_end & last_byte & reset_req;
	assign clear_done = frame_end & last_byte & clear_req;
	assign cursor_done = frame_end & last_byte & cursor_req;
	assign data_done = frame_end & last_byte & data_req;

	always_ff @(posedge lcdclk) begin
		if (lcdreset) begin
			byte_idx <= '0;
			in_flight <= 1'b0;
		end else begin
			if (start)
				byte_idx <= '0;
			else if (load)
				byte_idx <= byte_idx + 1'b1;
			if (load)
				in_flight <= 1'b1;
			else if (frame_end)
				in_flight <= 1'b0;
		end
	end

endmodule

//--- src/lcd_bit_timer.sv
// ==============================
// lcd bit timer
// half-period ticks for sclk while a frame is active
// ==============================
`timescale 1ns/100ps

module lcd_bit_timer #(
	parameter int sclk_half = 4
) (
	input  logic lcdclk,
	input  logic lcdreset,
	input  logic busy,
	output logic tick
);

	localparam int cnt_w = $clog2(sclk_half + 1);
	localparam logic [cnt_w-1:0] wrap_val = cnt_w'(sclk_half - 1);

	logic [cnt_w-1:0] cnt;

	// parked at zero between frames so the first half-period is full length
	always_ff @(posedge lcdclk) begin
		if (lcdreset || !busy)
			cnt <= '0;
		else if (cnt == wrap_val)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	assign tick = busy & (cnt == wrap_val);

endmodule

//--- src/lcd_spi_shifter.sv
// ==============================
// lcd spi shifter
// frames one byte msb first on ss, mosi and sclk
// ==============================
`timescale 1ns/100ps

module lcd_spi_shifter (
	input  logic lcdclk,
	input  logic lcdreset,
	input  logic load,
	input  lcd_pkg::char_t tx_byte,
	input  logic tick,
	output logic busy,
	output logic ss,
	output logic mosi,
	output logic sclk
);

	localparam logic [4:0] ss_rise_cnt = 5'd16;  // after 8 full sclk periods
	localparam logic [4:0] gap_end_cnt = 5'd18;  // two more half-periods with ss high

	logic [4:0] half_cnt;
	lcd_pkg::char_t shift_reg;
	logic fall_edge;

	assign fall_edge = tick & sclk & (half_cnt < ss_rise_cnt);

	always_ff @(posedge lcdclk) begin
		if (lcdreset) begin
			busy <= 1'b0;
			ss <= 1'b1;
			sclk <= 1'b0;
			mosi <= 1'b0;
			half_cnt <= '0;
		end else if (load) begin
			busy <= 1'b1;
			ss <= 1'b0;
			mosi <= tx_byte[7];
			half_cnt <= '0;
		end else if (tick) begin
			half_cnt <= half_cnt + 1'b1;
			if (half_cnt < ss_rise_cnt)
				sclk <= ~sclk;
			if (fall_edge)
				mosi <= shift_reg[6];  // next bit goes out on the falling edge
			if (half_cnt == ss_rise_cnt)
				ss <= 1'b1;
			if (half_cnt == gap_end_cnt)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge lcdclk) begin
		if (load)
			shift_reg <= tx_byte;
		else if (fall_edge)
			shift_reg <= shift_reg << 1;
	end

endmodule

//--- src/lcd_serial_top.sv
// ==============================
// lcd serial top
// test driver that writes a fixed message to an SPI character LCD
// ==============================
`timescale 1ns/100ps

module lcd_serial_top #(
	parameter int msg_len = 11,
	parameter logic [lcd_pkg::byte_w*msg_len-1:0] message = "hello world",
	parameter int start_col = 2,
	parameter int sclk_half = 4
) (
	input  logic lcdclk,
	input  logic lcdreset,
	input  logic hold,
	output logic ss,
	output logic mosi,
	output logic sclk
);

	logic start;
	logic reset_req, clear_req, cursor_req, data_req;
	logic reset_done, clear_done, cursor_done, data_done;
	lcd_pkg::char_t char_out;
	lcd_pkg::char_t tx_byte;
	logic load;
	logic busy;
	logic tick;

	lcd_sequencer #(.msg_len(msg_len), .message(message)) u_sequencer (
		.lcdclk(lcdclk), .lcdreset(lcdreset), .hold(hold),
		.reset_done(reset_done), .clear_done(clear_done),
		.cursor_done(cursor_done), .data_done(data_done),
		.start(start), .reset_req(reset_req), .clear_req(clear_req),
		.cursor_req(cursor_req), .data_req(data_req), .char_out(char_out)
	);

	lcd_command_encoder #(.start_col(start_col)) u_encoder (
		.lcdclk(lcdclk), .lcdreset(lcdreset), .start(start),
		.reset_req(reset_req), .clear_req(clear_req),
		.cursor_req(cursor_req), .data_req(data_req), .char_in(char_out),
		.busy(busy), .load(load), .tx_byte(tx_byte),
		.reset_done(reset_done), .clear_done(clear_done),
		.cursor_done(cursor_done), .data_done(data_done)
	);

	lcd_bit_timer #(.sclk_half(sclk_half)) u_timer (
		.lcdclk(lcdclk), .lcdreset(lcdreset), .busy(busy), .tick(tick)
	);

	lcd_spi_shifter u_shifter (
		.lcdclk(lcdclk), .lcdreset(lcdreset), .load(load), .tx_byte(tx_byte),
		.tick(tick), .busy(busy), .ss(ss), .mosi(mosi), .sclk(sclk)
	);

endmodule

//--- testbench/lcd_serial_asserts.sv
// ==============================
// lcd serial assertions
// SPI framing and command completion, bound into the top level
// ==============================
`timescale 1ns/100ps

module lcd_serial_asserts (
	input logic lcdclk,
	input logic lcdreset,
	input logic ss,
	input logic mosi,
	input logic sclk,
	input logic busy,
	input logic reset_done,
	input logic clear_done,
	input logic cursor_done,
	input logic data_done
);

	int fail_count = 0;

	// sclk idles low whenever the display is deselected
	sclk_low_idle: assert property (@(posedge lcdclk) disable iff (lcdreset) ss |-> !sclk)
		else begin
			fail_count++;
			$error("sclk high while ss is high");
		end

	mosi_stable: assert property (@(posedge lcdclk) disable iff (lcdreset)
		sclk |-> $stable(mosi))  // covers the rising edge itself
		else begin
			fail_count++;
			$error("mosi changed around or during sclk high");
		end

	// a command only completes as the frame of its last byte releases the shifter
	done_at_frame_end: assert property (@(posedge lcdclk) disable iff (lcdreset)
		(reset_done | clear_done | cursor_done | data_done) |-> $fell(busy))
		else begin
			fail_count++;
			$error("done pulse away from the end of a frame");
		end

endmodule

bind lcd_serial_top lcd_serial_asserts u_asserts (
	.lcdclk(lcdclk), .lcdreset(lcdreset), .ss(ss), .mosi(mosi), .sclk(sclk),
	.busy(busy), .reset_done(reset_done), .clear_done(clear_done),
	.cursor_done(cursor_done), .data_done(data_done)
);

//--- testbench/lcd_serial_tb.sv
// ==============================
// lcd serial testbench
// replays the golden byte stream and checks every SPI frame
// ==============================
`timescale 1ns/100ps

module lcd_serial_tb;

	localparam int sclk_half = 2;
	localparam int gap_cycles = 2 * sclk_half;
	localparam int reset_cycles = 8;

	logic lcdclk;
	logic lcdreset;
	logic hold;
	logic ss;
	logic mosi;
	logic sclk;

	logic [7:0] gold_q[$];
	int hold_after[$];  // bytes seen before each hold starts
	int hold_len[$];
	int hold_total = 0;
	int n_seen = 0;
	int mismatches = 0;
	int other_errors = 0;

	logic sclk_d;
	logic ss_d;
	logic [7:0] rx_shift;
	logic [3:0] rise_cnt;

	lcd_serial_top #(.start_col(2), .sclk_half(sclk_half)) DUT (
		.lcdclk(lcdclk), .lcdreset(lcdreset), .hold(hold),
		.ss(ss), .mosi(mosi), .sclk(sclk)
	);

	always #50 lcdclk = ~lcdclk;

	task automatic read_golden();
		int fd;
		int n;
		logic [7:0] v;
		logic [8*8-1:0] tok;
		logic [8*128-1:0] rest;
		fd = $fopen("testbench/lcd_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file testbench/lcd_golden.txt");
			other_errors++;
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				void'($fgets(rest, fd));  // rest of a comment line
			end else if (tok == "hold") begin
				void'($fscanf(fd, "%d", n));
				hold_after.push_back(gold_q.size());
				hold_len.push_back(n);
				hold_total += n;
			end else if (tok != "byte") begin
				void'($sscanf(tok, "%h", v));
				gold_q.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	task automatic check_byte(input logic [7:0] got);
		if (n_seen < gold_q.size()) begin
			if (got !== gold_q[n_seen]) begin
				$display("[ERROR] %0d ns: mosi byte %0d expected %02h, actual %02h",
					$time, n_seen, gold_q[n_seen], got);
				mismatches++;
			end
			n_seen++;
		end
	endtask

	task automatic finish_run();
		$display("bytes seen %0d of %0d, byte errors %0d, other errors %0d, %s %0d",
			n_seen, gold_q.size(), mismatches, other_errors, "assertion failures",
			DUT.u_asserts.fail_count);
		if (mismatches + other_errors + DUT.u_asserts.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic watchdog(input int limit);
		repeat (limit) @(posedge lcdclk);
		$display("timeout after %0d cycles, %0d golden bytes never seen",
			limit, gold_q.size() - n_seen);
		other_errors++;
		finish_run();
	endtask

	// byte capture samples the values settled before each lcdclk edge
	always @(posedge lcdclk) begin
		if (lcdreset) begin
			sclk_d <= 1'b0;
			ss_d <= 1'b1;
			rx_shift <= '0;
			rise_cnt <= '0;
		end else begin
			sclk_d <= sclk;
			ss_d <= ss;
			if (sclk && !sclk_d && !ss)
				rx_shift <= {rx_shift[6:0], mosi};  // msb arrives first
			if (!ss && ss_d)
				rise_cnt <= '0;
			else if (sclk && !sclk_d && !ss)
				rise_cnt <= rise_cnt + 1'b1;
			if (!ss && ss_d && hold) begin
				$display("a frame started at %0d ns while hold was high", $time);
				other_errors++;
			end
			if (ss && !ss_d) begin
				if (rise_cnt != 4'd8) begin
					$display("[ERROR] %0d ns: sclk rising edges expected 8, actual %0d",
						$time, rise_cnt);
					mismatches++;
				end
				check_byte(rx_shift);
			end
		end
	end

	initial begin
		int limit;
		lcdclk = 1'b0;
		lcdreset = 1'b1;
		hold = 1'b0;
		read_golden();
		// each byte gets its 16 half periods, the gap twice over and some slack
		limit = gold_q.size() * (16 * sclk_half + 2 * gap_cycles + 10) +
			hold_total + reset_cycles + 200;
		fork
			watchdog(limit);
		join_none
		repeat (reset_cycles) @(posedge lcdclk);
		lcdreset <= 1'b0;
		if (ss !== 1'b1) begin
			$display("[ERROR] %0d ns: ss expected 1, actual %b", $time, ss);
			mismatches++;
		end
		foreach (hold_after[i]) begin
			wait (n_seen == hold_after[i]);
			@(posedge lcdclk);
			hold <= 1'b1;
			repeat (hold_len[i]) @(posedge lcdclk);
			hold <= 1'b0;
		end
		wait (n_seen == gold_q.size());
		repeat (4) @(posedge lcdclk);
		finish_run();
	end

endmodule

//--- testbench/lcd_golden.txt
# byte lines list the expected mosi bytes in hex, in the order they go out
# hold n raises hold for n cycles once the previous byte has ended
byte 1b 5b 2a
byte 1b 5b 6a
byte 1b 5b 30 3b 32 48
byte 68 65 6c 6c 6f 20
byte 77 6f 72 6c 64
byte 1b 5b 2a
byte 1b 5b 6a
byte 1b 5b 30 3b 32 48
byte 68 65 6c 6c 6f 20
byte 77 6f 72 6c 64
byte 1b 5b 2a
byte 1b 5b 6a
byte 1b 5b 30 3b 32 48
byte 68 65 6c
hold 60
byte 1b 5b 2a
byte 1b 5b 6a

//--- src.f
src/lcd_pkg.sv
src/lcd_sequencer.sv
src/lcd_command_encoder.sv
src/lcd_bit_timer.sv
src/lcd_spi_shifter.sv
src/lcd_serial_top.sv
testbench/lcd_serial_asserts.sv
testbench/lcd_serial_tb.sv

//--- Bender.yml
package:
  name: lcd_serial

sources:
  - src/lcd_pkg.sv
  - src/lcd_sequencer.sv
  - src/lcd_command_encoder.sv
  - src/lcd_bit_timer.sv
  - src/lcd_spi_shifter.sv
  - src/lcd_serial_top.sv
  - target: test
    files:
      - testbench/lcd_serial_asserts.sv
      - testbench/lcd_serial_tb.sv
